// File: hdl/decode_pkg.sv
package decode_pkg;

   localparam int ir_bytes = 16;
   localparam int eip_w    = 32;
   localparam int reg_id_w = 3;

   // segment register ids
   localparam logic [2:0] seg_es = 3'd0;
   localparam logic [2:0] seg_cs = 3'd1;
   localparam logic [2:0] seg_ss = 3'd2;
   localparam logic [2:0] seg_ds = 3'd3;
   localparam logic [2:0] seg_fs = 3'd4;
   localparam logic [2:0] seg_gs = 3'd5;

   typedef enum logic [3:0] {
      op_add_rm_r,
      op_add_eax_imm,
      op_mov_r_rm,
      op_mov_rm_imm,
      op_push_seg,
      op_jmp_rel,
      op_movq_mm,
      op_cmpxchg,
      op_invalid
   } x86_op_e;

   // same numbering as the modrm reg field of the group-1 opcodes
   typedef enum logic [2:0] {
      alu_add,
      alu_or,
      alu_adc,
      alu_sbb,
      alu_and,
      alu_sub,
      alu_xor,
      alu_pass
   } alu_op_e;

   typedef enum logic [1:0] {
      disp_none,
      disp_8,
      disp_32
   } disp_size_e;

   typedef enum logic [1:0] {
      imm_none,
      imm_16,
      imm_32
   } imm_size_e;

   typedef struct packed {
      logic                    valid;
      logic [ir_bytes*8-1:0]   ir;
      logic [eip_w-1:0]        eip;
      logic [15:0]             cs;
   } fetch_t;

   typedef struct packed {
      logic                    valid;
      logic [ir_bytes*8-1:0]   ir;
      logic [eip_w-1:0]        eip;
      logic [15:0]             cs;
      x86_op_e                 op;
      logic [7:0]              modrm;
      logic [7:0]              sib;
      logic                    operand_override;
      logic                    segment_override;
      logic [2:0]              prefix_seg;
      logic                    modrm_present;
      logic                    sib_present;
      disp_size_e              disp_size;
      logic [3:0]              disp_pos;
      imm_size_e               imm_size;
      logic [3:0]              imm_pos;
      logic [3:0]              length;
   } d1_t;

   // one microcode word, mux_* bits select the modrm-derived value
   typedef struct packed {
      alu_op_e                 aluk;
      logic                    mux_aluk;
      logic                    mem_rd;
      logic                    mem_wr;
      logic                    mux_mem;
      logic                    ld_gpr;
      logic                    mux_ld_gpr;
      logic                    ld_mm;
      logic                    mm1_needed;
      logic                    sr1_needed;
      logic [reg_id_w-1:0]     sr1_fixed;
      logic                    mux_sr1;
      logic                    seg2_reg;
   } ctrl_word_t;

   typedef struct packed {
      logic                    valid;
      logic [eip_w-1:0]        next_eip;
      logic [15:0]             cs;
      alu_op_e                 aluk;
      logic                    mem_rd;
      logic                    mem_wr;
      logic                    ld_gpr;
      logic                    ld_mm;
      logic [reg_id_w-1:0]     sr1;
      logic [reg_id_w-1:0]     sr2;
      logic [reg_id_w-1:0]     sr3;
      logic [reg_id_w-1:0]     sr4;
      logic [2:0]              seg1;
      logic [2:0]              seg2;
      logic [1:0]              data_size;
      logic [31:0]             disp32;
      logic [31:0]             imm32;
      logic                    sr1_needed;
      logic                    mm1_needed;
      logic                    cmpxchg;
      logic                    invalid;
   } uop_t;

endpackage

// File: hdl/field_selector.sv
`timescale 1ns/100ps

module field_selector (
   input  logic [decode_pkg::ir_bytes*8-1:0] ir,
   input  decode_pkg::disp_size_e            disp_size,
   input  logic [3:0]                        disp_pos,
   input  decode_pkg::imm_size_e             imm_size,
   input  logic [3:0]                        imm_pos,
   output logic [31:0]                       disp32,
   output logic [31:0]                       imm32
);

   // three spare bytes so a 4-byte pick never runs off the window
   logic [(decode_pkg::ir_bytes+3)*8-1:0] ir_ext;
   logic [31:0]                           disp_raw;
   logic [31:0]                           imm_raw;

   assign ir_ext   = {24'h000000, ir};

   // little endian, lowest byte at the given position
   assign disp_raw = ir_ext[8*disp_pos +: 32];
   assign imm_raw  = ir_ext[8*imm_pos +: 32];

   always_comb begin
      case (disp_size)
         decode_pkg::disp_8:  disp32 = {{24{disp_raw[7]}}, disp_raw[7:0]};
         decode_pkg::disp_32: disp32 = disp_raw;
         default:             disp32 = 32'h0;
      endcase
   end

   always_comb begin
      case (imm_size)
         decode_pkg::imm_16: imm32 = {16'h0000, imm_raw[15:0]};
         decode_pkg::imm_32: imm32 = imm_raw;
         default:            imm32 = 32'h0;
      endcase
   end

endmodule

// File: hdl/ucontrol_store.sv
`timescale 1ns/100ps

module ucontrol_store (
   input  decode_pkg::x86_op_e     op,
   output decode_pkg::ctrl_word_t  control_signal
);

   always_comb begin
      control_signal = '0;
      case (op)
         decode_pkg::op_add_rm_r: begin
            control_signal.aluk       = decode_pkg::alu_add;
            control_signal.mem_rd     = 1'b1;
            control_signal.mem_wr     = 1'b1;
            control_signal.mux_mem    = 1'b1;
            control_signal.mux_ld_gpr = 1'b1;
            control_signal.sr1_needed = 1'b1;
         end
         decode_pkg::op_add_eax_imm: begin
            // accumulator form, eax is id 0
            control_signal.aluk       = decode_pkg::alu_add;
            control_signal.ld_gpr     = 1'b1;
            control_signal.sr1_needed = 1'b1;
            control_signal.sr1_fixed  = 3'd0;
            control_signal.mux_sr1    = 1'b1;
         end
         decode_pkg::op_mov_r_rm: begin
            control_signal.aluk       = decode_pkg::alu_pass;
            control_signal.mem_rd     = 1'b1;
            control_signal.mux_mem    = 1'b1;
            control_signal.ld_gpr     = 1'b1;
            control_signal.sr1_needed = 1'b1;
         end
         decode_pkg::op_mov_rm_imm: begin
            control_signal.aluk       = decode_pkg::alu_pass;
            control_signal.mem_wr     = 1'b1;
            control_signal.mux_mem    = 1'b1;
            control_signal.mux_ld_gpr = 1'b1;
            control_signal.sr1_needed = 1'b1;
         end
         decode_pkg::op_push_seg: begin
            // stack pointer is the address base
            control_signal.aluk       = decode_pkg::alu_pass;
            control_signal.mem_wr     = 1'b1;
            control_signal.sr1_needed = 1'b1;
            control_signal.sr1_fixed  = 3'd4;
            control_signal.mux_sr1    = 1'b1;
         end
         decode_pkg::op_jmp_rel: begin
            control_signal.aluk       = decode_pkg::alu_add;
         end
         decode_pkg::op_movq_mm: begin
            control_signal.aluk       = decode_pkg::alu_pass;
            control_signal.mem_wr     = 1'b1;
            control_signal.mux_mem    = 1'b1;
            control_signal.mm1_needed = 1'b1;
         end
         decode_pkg::op_cmpxchg: begin
            control_signal.aluk       = decode_pkg::alu_sub;
            control_signal.mem_rd     = 1'b1;
            control_signal.mem_wr     = 1'b1;
            control_signal.mux_mem    = 1'b1;
            control_signal.ld_gpr     = 1'b1;
            control_signal.sr1_needed = 1'b1;
         end
         default: control_signal = '0;
      endcase
   end

endmodule

// File: hdl/prefix_opcode_decode.sv
`timescale 1ns/100ps

module prefix_opcode_decode (
   input  logic                clk,
   input  logic                rst_n,
   input  decode_pkg::fetch_t  fetch,
   output decode_pkg::d1_t     d1
);

   decode_pkg::d1_t  d1_n;
   decode_pkg::d1_t  d1_r;
   logic             valid_r;
   logic             in_prefix;
   logic             two_byte;
   logic [7:0]       pbyte;
   logic [7:0]       opc1;
   logic [7:0]       opc2;
   logic [3:0]       opc_pos;
   logic [3:0]       modrm_pos;
   logic [3:0]       field_pos;
   logic [3:0]       disp_bytes;
   logic [3:0]       imm_bytes;

   function automatic logic [7:0] win_byte(input logic [decode_pkg::ir_bytes*8-1:0] ir,
                                           input logic [3:0] idx);
      return ir[8*idx +: 8];
   endfunction

   always_comb begin
      d1_n            = '0;
      d1_n.valid      = fetch.valid;
      d1_n.ir         = fetch.ir;
      d1_n.eip        = fetch.eip;
      d1_n.cs         = fetch.cs;
      d1_n.prefix_seg = decode_pkg::seg_ds;
      d1_n.op         = decode_pkg::op_invalid;
      d1_n.disp_size  = decode_pkg::disp_none;
      d1_n.imm_size   = decode_pkg::imm_none;
      opc_pos         = 4'd0;
      in_prefix       = 1'b1;

      // prefix scan, last segment byte wins
      for (int i = 0; i < 4; i++) begin
         pbyte = fetch.ir[8*i +: 8];
         if (in_prefix) begin
            case (pbyte)
               8'h66:   d1_n.operand_override = 1'b1;
               8'h26:   d1_n.prefix_seg = decode_pkg::seg_es;
               8'h2e:   d1_n.prefix_seg = decode_pkg::seg_cs;
               8'h36:   d1_n.prefix_seg = decode_pkg::seg_ss;
               8'h3e:   d1_n.prefix_seg = decode_pkg::seg_ds;
               8'h64:   d1_n.prefix_seg = decode_pkg::seg_fs;
               8'h65:   d1_n.prefix_seg = decode_pkg::seg_gs;
               default: in_prefix = 1'b0;
            endcase
            if (in_prefix) begin
               opc_pos = opc_pos + 4'd1;
               if (pbyte != 8'h66)
                  d1_n.segment_override = 1'b1;
            end
         end
      end

      opc1     = win_byte(fetch.ir, opc_pos);
      opc2     = win_byte(fetch.ir, opc_pos + 4'd1);
      two_byte = (opc1 == 8'h0f);

      if (two_byte) begin
         case (opc2)
            8'h7f:        d1_n.op = decode_pkg::op_movq_mm;
            8'hb0, 8'hb1: d1_n.op = decode_pkg::op_cmpxchg;
            default:      d1_n.op = decode_pkg::op_invalid;
         endcase
      end else begin
         case (opc1)
            8'h01:               d1_n.op = decode_pkg::op_add_rm_r;
            8'h05:               d1_n.op = decode_pkg::op_add_eax_imm;
            8'h8b:               d1_n.op = decode_pkg::op_mov_r_rm;
            8'hc7:               d1_n.op = decode_pkg::op_mov_rm_imm;
            8'h06, 8'h16, 8'h1e: d1_n.op = decode_pkg::op_push_seg;
            8'he9:               d1_n.op = decode_pkg::op_jmp_rel;
            default:             d1_n.op = decode_pkg::op_invalid;
         endcase
      end

      case (d1_n.op)
         decode_pkg::op_add_rm_r, decode_pkg::op_mov_r_rm, decode_pkg::op_mov_rm_imm,
         decode_pkg::op_movq_mm, decode_pkg::op_cmpxchg: d1_n.modrm_present = 1'b1;
         default:                                       d1_n.modrm_present = 1'b0;
      endcase

      modrm_pos = opc_pos + {3'b000, two_byte} + 4'd1;

      // modrm and sib stay zero when absent
      if (d1_n.modrm_present) begin
         d1_n.modrm       = win_byte(fetch.ir, modrm_pos);
         d1_n.sib_present = (d1_n.modrm[7:6] != 2'b11) && (d1_n.modrm[2:0] == 3'b100);
         if (d1_n.sib_present)
            d1_n.sib = win_byte(fetch.ir, modrm_pos + 4'd1);
         case (d1_n.modrm[7:6])
            2'b01: d1_n.disp_size = decode_pkg::disp_8;
            2'b10: d1_n.disp_size = decode_pkg::disp_32;
            2'b00: begin
               if (d1_n.modrm[2:0] == 3'b101 || (d1_n.sib_present && d1_n.sib[2:0] == 3'b101))
                  d1_n.disp_size = decode_pkg::disp_32;
            end
            default: d1_n.disp_size = decode_pkg::disp_none;
         endcase
      end

      case (d1_n.op)
         decode_pkg::op_add_eax_imm, decode_pkg::op_mov_rm_imm, decode_pkg::op_jmp_rel:
            d1_n.imm_size = d1_n.operand_override ? decode_pkg::imm_16 : decode_pkg::imm_32;
         default:
            d1_n.imm_size = decode_pkg::imm_none;
      endcase

      case (d1_n.disp_size)
         decode_pkg::disp_8:  disp_bytes = 4'd1;
         decode_pkg::disp_32: disp_bytes = 4'd4;
         default:             disp_bytes = 4'd0;
      endcase
      case (d1_n.imm_size)
         decode_pkg::imm_16: imm_bytes = 4'd2;
         decode_pkg::imm_32: imm_bytes = 4'd4;
         default:            imm_bytes = 4'd0;
      endcase

      // layout after the opcode: modrm, sib, disp, imm
      field_pos     = modrm_pos + {3'b000, d1_n.modrm_present} + {3'b000, d1_n.sib_present};
      d1_n.disp_pos = field_pos;
      d1_n.imm_pos  = field_pos + disp_bytes;
      d1_n.length   = d1_n.imm_pos + imm_bytes;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_r <= 1'b0;
      end else begin
         valid_r <= d1_n.valid;
      end
   end

   always_ff @(posedge clk) begin
      d1_r <= d1_n;
   end

   always_comb begin
      d1       = d1_r;
      d1.valid = valid_r;
   end

endmodule

// File: hdl/decode_stage2.sv
`timescale 1ns/100ps

module decode_stage2 (
   input  logic             clk,
   input  logic             rst_n,
   input  decode_pkg::d1_t  d1,
   output decode_pkg::uop_t uop
);

   decode_pkg::ctrl_word_t           cw;
   decode_pkg::uop_t                 uop_n;
   decode_pkg::uop_t                 uop_r;
   logic                             valid_r;
   logic [31:0]                      disp32;
   logic [31:0]                      imm32;
   logic                             mod_reg;
   logic                             mod_mem;
   logic                             is_movq;
   logic                             ss_base;
   logic [decode_pkg::reg_id_w-1:0]  base_id;
   logic [3:0]                       opc_idx;
   logic [7:0]                       push_opc;

   field_selector u_field_selector (
      .ir        (d1.ir),
      .disp_size (d1.disp_size),
      .disp_pos  (d1.disp_pos),
      .imm_size  (d1.imm_size),
      .imm_pos   (d1.imm_pos),
      .disp32    (disp32),
      .imm32     (imm32)
   );

   ucontrol_store u_ucontrol_store (
      .op             (d1.op),
      .control_signal (cw)
   );

   assign mod_reg = (d1.modrm[7:6] == 2'b11);
   assign mod_mem = !mod_reg;
   assign is_movq = (d1.op == decode_pkg::op_movq_mm);
   assign base_id = d1.sib_present ? d1.sib[2:0] : d1.modrm[2:0];

   // push is one byte, so its opcode is the last byte of the instruction
   assign opc_idx  = d1.length - 4'd1;
   assign push_opc = d1.ir[8*opc_idx +: 8];

   // esp base, or ebp base with a displacement
   assign ss_base = d1.modrm_present && mod_mem &&
                    (base_id == 3'd4 || (base_id == 3'd5 && d1.modrm[7:6] != 2'b00));

   always_comb begin
      uop_n            = '0;
      uop_n.valid      = d1.valid;
      uop_n.cs         = d1.cs;
      uop_n.next_eip   = d1.eip + {{(decode_pkg::eip_w-4){1'b0}}, d1.length};
      uop_n.disp32     = disp32;
      uop_n.imm32      = imm32;

      uop_n.aluk   = cw.mux_aluk ? decode_pkg::alu_op_e'(d1.modrm[5:3]) : cw.aluk;
      uop_n.mem_rd = cw.mux_mem ? (cw.mem_rd & mod_mem) : cw.mem_rd;
      uop_n.mem_wr = cw.mux_mem ? (cw.mem_wr & mod_mem) : cw.mem_wr;
      uop_n.ld_gpr = cw.mux_ld_gpr ? mod_reg : cw.ld_gpr;

      // movq register form writes the mm file
      uop_n.ld_mm      = cw.ld_mm | (mod_reg & is_movq);
      uop_n.mm1_needed = cw.mm1_needed & mod_reg & !is_movq;
      uop_n.sr1_needed = cw.sr1_needed | (cw.mm1_needed & mod_mem);

      uop_n.sr1 = cw.mux_sr1 ? cw.sr1_fixed : base_id;
      uop_n.sr2 = d1.modrm[5:3];
      uop_n.sr3 = d1.modrm[5:3];
      uop_n.sr4 = d1.sib[5:3];

      if (d1.segment_override)
         uop_n.seg1 = d1.prefix_seg;
      else if (d1.op == decode_pkg::op_push_seg)
         uop_n.seg1 = {1'b0, push_opc[4:3]};
      else if (ss_base)
         uop_n.seg1 = decode_pkg::seg_ss;
      else
         uop_n.seg1 = decode_pkg::seg_ds;
      uop_n.seg2 = cw.seg2_reg ? d1.modrm[5:3] : decode_pkg::seg_ss;

      uop_n.data_size = d1.operand_override ? 2'b01 : 2'b10;
      uop_n.cmpxchg   = (d1.op == decode_pkg::op_cmpxchg);
      uop_n.invalid   = (d1.op == decode_pkg::op_invalid);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_r <= 1'b0;
      end else begin
         valid_r <= uop_n.valid;
      end
   end

   always_ff @(posedge clk) begin
      uop_r <= uop_n;
   end

   always_comb begin
      uop       = uop_r;
      uop.valid = valid_r;
   end

endmodule

// File: hdl/decode_top.sv
`timescale 1ns/100ps

module decode_top (
   input  logic               clk,
   input  logic               rst_n,
   input  decode_pkg::fetch_t fetch,
   output decode_pkg::uop_t   uop
);

   // stage one result, one item per cycle
   decode_pkg::d1_t d1;

   prefix_opcode_decode u_prefix_opcode_decode (
      .clk   (clk),
      .rst_n (rst_n),
      .fetch (fetch),
      .d1    (d1)
   );

   decode_stage2 u_decode_stage2 (
      .clk   (clk),
      .rst_n (rst_n),
      .d1    (d1),
      .uop   (uop)
   );

endmodule

// File: tests/decode_tb.sv
`timescale 1ns/100ps

module decode_tb;

   localparam int n_items    = 400;
   localparam int clk_period = 8;
   localparam int time_limit = n_items * 2 * clk_period + 400;

   logic                  clk;
   logic                  rst_n;
   decode_pkg::fetch_t    fetch;
   decode_pkg::uop_t      uop;

   decode_pkg::uop_t      exp_q[$];
   int                    due_q[$];
   int                    edge_cnt = 0;
   logic [31:0]           lfsr_state = 32'hfba;

   decode_top uut (
      .clk   (clk),
      .rst_n (rst_n),
      .fetch (fetch),
      .uop   (uop)
   );

   initial clk = 1'b0;
   always #(clk_period / 2) clk = ~clk;

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   // {hit, segment id} for a segment override byte
   function automatic logic [3:0] seg_prefix(input logic [7:0] b);
      case (b)
         8'h26:   return {1'b1, decode_pkg::seg_es};
         8'h2e:   return {1'b1, decode_pkg::seg_cs};
         8'h36:   return {1'b1, decode_pkg::seg_ss};
         8'h3e:   return {1'b1, decode_pkg::seg_ds};
         8'h64:   return {1'b1, decode_pkg::seg_fs};
         8'h65:   return {1'b1, decode_pkg::seg_gs};
         default: return 4'h0;
      endcase
   endfunction

   function automatic logic [31:0] pick_le(input logic [127:0] ir, input int pos, input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++)
         v[8*k +: 8] = ir[8*(pos+k) +: 8];
      return v;
   endfunction

   function automatic decode_pkg::uop_t decode_ref(input decode_pkg::fetch_t f);
      decode_pkg::uop_t    u;
      decode_pkg::x86_op_e op;
      logic [7:0]          opc;
      logic [7:0]          opc2;
      logic [7:0]          modrm;
      logic [7:0]          sib;
      logic [3:0]          sp;
      logic [2:0]          pseg;
      logic [2:0]          base;
      logic                opsz;
      logic                segov;
      logic                stop;
      logic                two;
      logic                has_modrm;
      logic                has_sib;
      logic                reg_form;
      logic                mem;
      int                  p;
      int                  dlen;
      int                  ilen;
      u     = '0;
      p     = 0;
      opsz  = 1'b0;
      segov = 1'b0;
      stop  = 1'b0;
      pseg  = decode_pkg::seg_ds;
      while (p < 4 && !stop) begin
         sp = seg_prefix(f.ir[8*p +: 8]);
         if (f.ir[8*p +: 8] == 8'h66) begin
            opsz = 1'b1;
            p = p + 1;
         end else if (sp[3]) begin
            segov = 1'b1;
            pseg = sp[2:0];
            p = p + 1;
         end else begin
            stop = 1'b1;
         end
      end
      opc  = f.ir[8*p +: 8];
      opc2 = f.ir[8*(p+1) +: 8];
      two  = (opc == 8'h0f);
      op   = decode_pkg::op_invalid;
      if (two) begin
         if (opc2 == 8'h7f)
            op = decode_pkg::op_movq_mm;
         else if (opc2 == 8'hb0 || opc2 == 8'hb1)
            op = decode_pkg::op_cmpxchg;
      end else begin
         case (opc)
            8'h01:               op = decode_pkg::op_add_rm_r;
            8'h05:               op = decode_pkg::op_add_eax_imm;
            8'h8b:               op = decode_pkg::op_mov_r_rm;
            8'hc7:               op = decode_pkg::op_mov_rm_imm;
            8'h06, 8'h16, 8'h1e: op = decode_pkg::op_push_seg;
            8'he9:               op = decode_pkg::op_jmp_rel;
            default:             op = decode_pkg::op_invalid;
         endcase
      end
      p = p + 1 + int'(two);

      has_modrm = op inside {decode_pkg::op_add_rm_r, decode_pkg::op_mov_r_rm,
                             decode_pkg::op_mov_rm_imm, decode_pkg::op_movq_mm,
                             decode_pkg::op_cmpxchg};
      modrm = has_modrm ? f.ir[8*p +: 8] : 8'h00;
      p = p + int'(has_modrm);
      reg_form = (modrm[7:6] == 2'b11);
      mem      = !reg_form;
      has_sib  = has_modrm && mem && (modrm[2:0] == 3'b100);
      sib      = has_sib ? f.ir[8*p +: 8] : 8'h00;
      p = p + int'(has_sib);
      base = has_sib ? sib[2:0] : modrm[2:0];

      // displacement bytes from mod, rm and the sib base
      dlen = 0;
      if (has_modrm && modrm[7:6] == 2'b01)
         dlen = 1;
      else if (has_modrm && modrm[7:6] == 2'b10)
         dlen = 4;
      else if (has_modrm && modrm[7:6] == 2'b00 && (modrm[2:0] == 3'b101 || base == 3'b101))
         dlen = 4;
      u.disp32 = pick_le(f.ir, p, dlen);
      if (dlen == 1)
         u.disp32 = {{24{u.disp32[7]}}, u.disp32[7:0]};
      p = p + dlen;

      ilen = 0;
      if (op inside {decode_pkg::op_add_eax_imm, decode_pkg::op_mov_rm_imm,
                     decode_pkg::op_jmp_rel})
         ilen = opsz ? 2 : 4;
      u.imm32 = pick_le(f.ir, p, ilen);
      p = p + ilen;

      u.valid     = 1'b1;
      u.next_eip  = f.eip + 32'(p);
      u.cs        = f.cs;
      u.sr1       = base;
      u.sr2       = modrm[5:3];
      u.sr3       = modrm[5:3];
      u.sr4       = sib[5:3];
      u.seg2      = decode_pkg::seg_ss;
      u.data_size = opsz ? 2'b01 : 2'b10;
      u.cmpxchg   = (op == decode_pkg::op_cmpxchg);
      u.invalid   = (op == decode_pkg::op_invalid);

      if (segov)
         u.seg1 = pseg;
      else if (op == decode_pkg::op_push_seg)
         u.seg1 = (opc == 8'h06) ? decode_pkg::seg_es :
                  (opc == 8'h16) ? decode_pkg::seg_ss : decode_pkg::seg_ds;
      else if (has_modrm && mem && (base == 3'd4 || (base == 3'd5 && modrm[7:6] != 2'b00)))
         u.seg1 = decode_pkg::seg_ss;
      else
         u.seg1 = decode_pkg::seg_ds;

      // mm1_needed never survives, movq is its only source
      case (op)
         decode_pkg::op_add_rm_r: begin
            u.aluk       = decode_pkg::alu_add;
            u.mem_rd     = mem;
            u.mem_wr     = mem;
            u.ld_gpr     = reg_form;
            u.sr1_needed = 1'b1;
         end
         decode_pkg::op_add_eax_imm: begin
            u.aluk       = decode_pkg::alu_add;
            u.ld_gpr     = 1'b1;
            u.sr1_needed = 1'b1;
            u.sr1        = 3'd0;
         end
         decode_pkg::op_mov_r_rm: begin
            u.aluk       = decode_pkg::alu_pass;
            u.mem_rd     = mem;
            u.ld_gpr     = 1'b1;
            u.sr1_needed = 1'b1;
         end
         decode_pkg::op_mov_rm_imm: begin
            u.aluk       = decode_pkg::alu_pass;
            u.mem_wr     = mem;
            u.ld_gpr     = reg_form;
            u.sr1_needed = 1'b1;
         end
         decode_pkg::op_push_seg: begin
            u.aluk       = decode_pkg::alu_pass;
            u.mem_wr     = 1'b1;
            u.sr1_needed = 1'b1;
            u.sr1        = 3'd4;
         end
         decode_pkg::op_movq_mm: begin
            u.aluk       = decode_pkg::alu_pass;
            u.mem_wr     = mem;
            u.ld_mm      = reg_form;
            u.sr1_needed = mem;
         end
         decode_pkg::op_cmpxchg: begin
            u.aluk       = decode_pkg::alu_sub;
            u.mem_rd     = mem;
            u.mem_wr     = mem;
            u.ld_gpr     = 1'b1;
            u.sr1_needed = 1'b1;
         end
         default: u.aluk = decode_pkg::alu_add;
      endcase
      return u;
   endfunction

   // random window, then prefixes and opcode written over its start
   task automatic make_item(output decode_pkg::fetch_t f, output logic idle);
      logic [31:0] r;
      logic [7:0]  win [0:15];
      logic [7:0]  seg_bytes [0:5];
      logic        has66;
      logic        lead66;
      int          p;
      int          cls;
      int          nseg;
      seg_bytes = '{8'h26, 8'h2e, 8'h36, 8'h3e, 8'h64, 8'h65};
      for (int i = 0; i < 16; i++) begin
         take_bits(8, r);
         win[i] = r[7:0];
      end
      take_bits(4, r);
      cls = int'(r % 9);
      take_bits(1, r);
      has66 = r[0];
      take_bits(1, r);
      lead66 = r[0];
      take_bits(2, r);
      nseg = int'(r % 3);
      p = 0;
      if (has66 && lead66) begin
         win[p] = 8'h66;
         p = p + 1;
      end
      for (int s = 0; s < nseg; s++) begin
         take_bits(3, r);
         win[p] = seg_bytes[r % 6];
         p = p + 1;
      end
      if (has66 && !lead66) begin
         win[p] = 8'h66;
         p = p + 1;
      end
      case (cls)
         0: win[p] = 8'h01;
         1: win[p] = 8'h05;
         2: win[p] = 8'h8b;
         3: win[p] = 8'hc7;
         4: begin
            take_bits(2, r);
            win[p] = (r % 3 == 0) ? 8'h06 : (r % 3 == 1) ? 8'h16 : 8'h1e;
         end
         5: win[p] = 8'he9;
         6: begin
            win[p]   = 8'h0f;
            win[p+1] = 8'h7f;
         end
         7: begin
            take_bits(1, r);
            win[p]   = 8'h0f;
            win[p+1] = {7'b1011000, r[0]};
         end
         default: begin
            take_bits(9, r);
            if (r[8]) begin
               win[p]   = 8'h0f;
               win[p+1] = (r[7:0] inside {8'h7f, 8'hb0, 8'hb1}) ? 8'h0b : r[7:0];
            end else begin
               win[p] = (r[7:0] inside {8'h01, 8'h05, 8'h8b, 8'hc7, 8'h06, 8'h16, 8'h1e,
                                        8'he9, 8'h0f, 8'h66, 8'h26, 8'h2e, 8'h36, 8'h3e,
                                        8'h64, 8'h65}) ? 8'h90 : r[7:0];
            end
         end
      endcase
      f = '0;
      f.valid = 1'b1;
      for (int i = 0; i < 16; i++)
         f.ir[8*i +: 8] = win[i];
      take_bits(32, r);
      f.eip = r;
      take_bits(16, r);
      f.cs = r[15:0];
      take_bits(2, r);
      idle = (r[1:0] == 2'b00);
   endtask

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "uop field mismatch");
      end
   endtask

   task automatic compare_uop(input decode_pkg::uop_t got, input decode_pkg::uop_t exp);
      check_field("next_eip", got.next_eip, exp.next_eip);
      check_field("cs", 32'(got.cs), 32'(exp.cs));
      check_field("aluk", 32'(got.aluk), 32'(exp.aluk));
      check_field("mem_rd", 32'(got.mem_rd), 32'(exp.mem_rd));
      check_field("mem_wr", 32'(got.mem_wr), 32'(exp.mem_wr));
      check_field("ld_gpr", 32'(got.ld_gpr), 32'(exp.ld_gpr));
      check_field("ld_mm", 32'(got.ld_mm), 32'(exp.ld_mm));
      check_field("sr1", 32'(got.sr1), 32'(exp.sr1));
      check_field("sr2", 32'(got.sr2), 32'(exp.sr2));
      check_field("sr3", 32'(got.sr3), 32'(exp.sr3));
      check_field("sr4", 32'(got.sr4), 32'(exp.sr4));
      check_field("seg1", 32'(got.seg1), 32'(exp.seg1));
      check_field("seg2", 32'(got.seg2), 32'(exp.seg2));
      check_field("data_size", 32'(got.data_size), 32'(exp.data_size));
      check_field("disp32", got.disp32, exp.disp32);
      check_field("imm32", got.imm32, exp.imm32);
      check_field("sr1_needed", 32'(got.sr1_needed), 32'(exp.sr1_needed));
      check_field("mm1_needed", 32'(got.mm1_needed), 32'(exp.mm1_needed));
      check_field("cmpxchg", 32'(got.cmpxchg), 32'(exp.cmpxchg));
      check_field("invalid", 32'(got.invalid), 32'(exp.invalid));
   endtask

   initial begin : drive_stimulus
      decode_pkg::fetch_t f;
      logic               idle;
      rst_n = 1'b0;
      fetch = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int n = 0; n < n_items; n++) begin
         make_item(f, idle);
         if (idle) begin
            fetch = '0;
            @(negedge clk);
         end
         fetch = f;
         exp_q.push_back(decode_ref(f));
         // sampled at the next edge, uop out one edge after that
         due_q.push_back(edge_cnt + 2);
         @(negedge clk);
      end
      fetch = '0;
      repeat (4) @(negedge clk);
      if (exp_q.size() != 0) begin
         $display("error: %0d items never came out of the decoder", exp_q.size());
         $display("SIMULATION FAILED");
         $fatal(1, "items left over");
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

   // outputs read just after each rising edge
   initial begin : compare_outputs
      decode_pkg::uop_t exp;
      int               due;
      forever begin
         @(posedge clk);
         edge_cnt = edge_cnt + 1;
         #1;
         if (due_q.size() > 0 && due_q[0] == edge_cnt) begin
            assert (uop.valid) else begin
               $display("error: expected uop missing at %0t ns", $time);
               $display("SIMULATION FAILED");
               $fatal(1, "missing uop");
            end
         end
         if (uop.valid) begin
            assert (exp_q.size() > 0) else begin
               $display("error: uop valid at %0t ns with no item outstanding", $time);
               $display("SIMULATION FAILED");
               $fatal(1, "unexpected uop");
            end
            exp = exp_q.pop_front();
            due = due_q.pop_front();
            check_field("latency edge", 32'(edge_cnt), 32'(due));
            compare_uop(uop, exp);
         end
      end
   end

   initial begin : watchdog
      #(time_limit);
      $display("error: run did not finish within %0d ns", time_limit);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
   end

endmodule

// File: compile.f
hdl/decode_pkg.sv
hdl/field_selector.sv
hdl/ucontrol_store.sv
hdl/prefix_opcode_decode.sv
hdl/decode_stage2.sv
hdl/decode_top.sv
tests/decode_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module decode_tb -f compile.f -o decode_sim

./obj_dir/decode_sim 2>&1 | tee sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
   echo "run ok"
   exit 0
else
   echo "run failed, see sim.log"
   exit 1
fi
